// ==== src/branch_pkg.sv ====
`default_nettype none

package branch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t; // opcode, rs, rt, imm / jump index.

    typedef enum logic [5:0] {
        OP_BTYPE = 6'd1, // REGIMM group, rt selects the branch.
        OP_J     = 6'd2,
        OP_JAL   = 6'd3,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_BLEZ  = 6'd6,
        OP_BGTZ  = 6'd7
    } opcode_t;

    typedef enum logic [4:0] {
        BR_BLTZ   = 5'd0,
        BR_BGEZ   = 5'd1,
        BR_BLTZAL = 5'd16,
        BR_BGEZAL = 5'd17
    } btype_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        word_t  rs_val;
        word_t  rt_val;
    } br_req_t;

    typedef struct packed {
        addr_t new_pc;
        logic  link;
        addr_t link_pc;
        logic  exc;     // reserved REGIMM code.
        logic  unknown; // not a branch opcode.
    } br_res_t;

    // link writes go to $ra.
    localparam logic [4:0] REG_RA = 5'd31;

    localparam int DEF_IN_DEPTH  = 4;
    localparam int DEF_OUT_DEPTH = 4;

endpackage

`default_nettype wire

// ==== src/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    parameter int  CREDITS   = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     credit_return,
    input  logic     credit_in,
    output logic     pop_valid,
    output payload_t pop_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt; // slots known free downstream.
    logic             wr_en;

    assign wr_en = push && (count != CNT_W'(DEPTH));

    // pop as soon as there is data and somewhere to put it.
    assign pop_valid     = (count != '0) && (credit_cnt != '0);
    assign pop_data      = mem[rd_ptr];
    assign credit_return = pop_valid;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CRD_W'(CREDITS);
        end else begin
            case ({credit_in, pop_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt; // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/branch_cond_eval.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_cond_eval import branch_pkg::*; (
    input  instr_t instr,
    input  word_t  rs_val,
    input  word_t  rt_val,
    output logic   taken,
    output logic   link,
    output logic   exc,
    output logic   unknown
);
    opcode_t opcode;
    btype_t  btype;

    assign opcode = opcode_t'(instr[31:26]);
    assign btype  = btype_t'(instr[20:16]); // rt field picks the REGIMM op.

    always_comb begin
        taken   = 1'b0;
        link    = 1'b0;
        exc     = 1'b0;
        unknown = 1'b0;
        case (opcode)
            OP_BEQ:  taken = (rs_val == rt_val);
            OP_BNE:  taken = (rs_val != rt_val);
            OP_BLEZ: taken = ($signed(rs_val) <= 0);
            OP_BGTZ: taken = ($signed(rs_val) > 0);
            OP_J:    taken = 1'b1;
            OP_JAL: begin
                taken = 1'b1;
                link  = 1'b1;
            end
            OP_BTYPE: begin
                case (btype)
                    BR_BLTZ, BR_BLTZAL: taken = ($signed(rs_val) < 0);
                    BR_BGEZ, BR_BGEZAL: taken = ($signed(rs_val) >= 0);
                    default:            exc   = 1'b1;
                endcase
                // AL forms link whether taken or not.
                link = (btype == BR_BLTZAL) || (btype == BR_BGEZAL);
            end
            default: unknown = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/branch_target_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_target_calc import branch_pkg::*; (
    input  addr_t  pc,
    input  instr_t instr,
    output addr_t  seq_pc,
    output addr_t  link_pc,
    output addr_t  target_pc,
    output addr_t  jump_pc
);
    logic [17:0] offset;
    addr_t       next_pc;

    assign offset  = {instr[15:0], 2'b00};
    assign next_pc = pc + 32'd4;

    // skip the delay slot.
    assign seq_pc  = pc + 32'd8;
    assign link_pc = pc + 32'd8;

    assign target_pc = next_pc + {{14{offset[17]}}, offset};
    assign jump_pc   = {pc[31:28], instr[25:0], 2'b00}; // same 256 MB region.

endmodule

`default_nettype wire

// ==== src/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import branch_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    valid,
    input  instr_t  instr,
    input  logic    taken,
    input  logic    link,
    input  logic    exc,
    input  logic    unknown,
    input  addr_t   seq_pc,
    input  addr_t   link_pc,
    input  addr_t   target_pc,
    input  addr_t   jump_pc,
    output logic    res_valid,
    output br_res_t res
);
    opcode_t opcode;
    logic    is_jump;
    logic    fault;
    br_res_t res_d;

    assign opcode  = opcode_t'(instr[31:26]);
    assign is_jump = (opcode == OP_J) || (opcode == OP_JAL);
    assign fault   = exc || unknown;

    always_comb begin
        res_d.link_pc = link_pc;
        res_d.exc     = exc;
        res_d.unknown = unknown;
        if (fault) begin
            // fall through, no register write.
            res_d.new_pc = seq_pc;
            res_d.link   = 1'b0;
        end else begin
            res_d.link = link;
            if (is_jump) begin
                res_d.new_pc = jump_pc;
            end else if (taken) begin
                res_d.new_pc = target_pc;
            end else begin
                res_d.new_pc = seq_pc;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            res <= res_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit import branch_pkg::*; #(
    parameter int IN_DEPTH    = DEF_IN_DEPTH,
    parameter int OUT_DEPTH   = DEF_OUT_DEPTH,
    parameter int OUT_CREDITS = DEF_OUT_DEPTH
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   in_valid,
    input  addr_t  in_pc,
    input  instr_t in_instr,
    input  word_t  in_rs_val,
    input  word_t  in_rt_val,
    output logic   in_credit,
    output logic   out_valid,
    output addr_t  out_new_pc,
    output logic   out_link,
    output addr_t  out_link_pc,
    output logic   out_exc,
    output logic   out_unknown,
    input  logic   out_credit
);
    br_req_t req_in, req;
    br_res_t res, res_out;
    logic    req_valid, res_valid;
    logic    res_credit; // result queue slot freed.
    logic    taken, link, exc, unknown;
    addr_t   seq_pc, link_pc, target_pc, jump_pc;

    assign req_in = '{pc: in_pc, instr: in_instr, rs_val: in_rs_val, rt_val: in_rt_val};

    // credits come from the result queue, so at most OUT_DEPTH in flight.
    credit_fifo #(
        .payload_t (br_req_t),
        .DEPTH     (IN_DEPTH),
        .CREDITS   (OUT_DEPTH)
    ) req_fifo_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (in_valid),
        .push_data     (req_in),
        .credit_return (in_credit),
        .credit_in     (res_credit),
        .pop_valid     (req_valid),
        .pop_data      (req)
    );

    branch_cond_eval cond_eval_inst (
        .instr   (req.instr),
        .rs_val  (req.rs_val),
        .rt_val  (req.rt_val),
        .taken   (taken),
        .link    (link),
        .exc     (exc),
        .unknown (unknown)
    );

    branch_target_calc target_calc_inst (
        .pc        (req.pc),
        .instr     (req.instr),
        .seq_pc    (seq_pc),
        .link_pc   (link_pc),
        .target_pc (target_pc),
        .jump_pc   (jump_pc)
    );

    branch_resolve resolve_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (req_valid),
        .instr     (req.instr),
        .taken     (taken),
        .link      (link),
        .exc       (exc),
        .unknown   (unknown),
        .seq_pc    (seq_pc),
        .link_pc   (link_pc),
        .target_pc (target_pc),
        .jump_pc   (jump_pc),
        .res_valid (res_valid),
        .res       (res)
    );

    credit_fifo #(
        .payload_t (br_res_t),
        .DEPTH     (OUT_DEPTH),
        .CREDITS   (OUT_CREDITS)
    ) res_fifo_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (res_valid),
        .push_data     (res),
        .credit_return (res_credit),
        .credit_in     (out_credit),
        .pop_valid     (out_valid),
        .pop_data      (res_out)
    );

    assign out_new_pc  = res_out.new_pc;
    assign out_link    = res_out.link;
    assign out_link_pc = res_out.link_pc;
    assign out_exc     = res_out.exc;
    assign out_unknown = res_out.unknown;

endmodule

`default_nettype wire

// ==== verification/branch_unit_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_clkgen (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk; // 10 ns period.
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/branch_unit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_checker import branch_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   in_valid,
    input  addr_t  in_pc,
    input  instr_t in_instr,
    input  word_t  in_rs_val,
    input  word_t  in_rt_val,
    input  int     test_id,
    input  logic   out_valid,
    input  addr_t  out_new_pc,
    input  logic   out_link,
    input  addr_t  out_link_pc,
    input  logic   out_exc,
    input  logic   out_unknown,
    input  logic   release_ok,
    output logic   out_credit,
    output int     error_count,
    output int     request_count,
    output int     result_count,
    output int     outstanding
);
    br_res_t exp_q[$];
    int      id_q[$];
    int      errors = 0;
    int      requests = 0;
    int      results = 0;
    int      pending = 0;
    int      freed = 0;  // result slots not yet credited back.
    logic    give_next = 1'b0;
    logic    credit_drv = 1'b0;

    assign out_credit    = credit_drv;
    assign error_count   = errors;
    assign request_count = requests;
    assign result_count  = results;
    assign outstanding   = pending;

    function automatic br_res_t expect_result(input addr_t pc, input instr_t instr,
                                              input word_t rs, input word_t rt);
        br_res_t    r;
        logic [5:0] op;
        logic [4:0] sel;
        addr_t      target;
        addr_t      jump;
        op     = instr[31:26];
        sel    = instr[20:16];
        target = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        jump   = {pc[31:28], instr[25:0], 2'b00};
        r      = '{new_pc: pc + 32'd8, link: 1'b0, link_pc: pc + 32'd8, exc: 1'b0, unknown: 1'b0};
        case (op)
            6'd4: if (rs == rt) r.new_pc = target;
            6'd5: if (rs != rt) r.new_pc = target;
            6'd6: if ($signed(rs) <= 0) r.new_pc = target;
            6'd7: if ($signed(rs) > 0) r.new_pc = target;
            6'd2: r.new_pc = jump;
            6'd3: begin
                r.new_pc = jump;
                r.link   = 1'b1;
            end
            6'd1: begin
                if (sel == 5'd0 || sel == 5'd16) begin
                    r.link = sel[4];
                    if ($signed(rs) < 0) r.new_pc = target;
                end else if (sel == 5'd1 || sel == 5'd17) begin
                    r.link = sel[4];
                    if ($signed(rs) >= 0) r.new_pc = target;
                end else begin
                    r.exc = 1'b1; // reserved rt code.
                end
            end
            default: r.unknown = 1'b1;
        endcase
        return r;
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1:       return "cond_branch";
            2:       return "regimm";
            3:       return "jump";
            4:       return "fault";
            5:       return "random_backpressure";
            default: return "startup";
        endcase
    endfunction

    task automatic compare_field(input int id, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_label(id), field,
                     expected, actual);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        br_res_t expected;
        int      id;
        if (!arst_n) begin
            give_next = 1'b0;
        end else begin
            if (in_valid) begin
                exp_q.push_back(expect_result(in_pc, in_instr, in_rs_val, in_rt_val));
                id_q.push_back(test_id);
                requests++;
            end
            if (out_valid) begin
                results++;
                freed++;
                if (exp_q.size() == 0) begin
                    $display("a result arrived with no request outstanding");
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    id       = id_q.pop_front();
                    compare_field(id, "new_pc", expected.new_pc, out_new_pc);
                    compare_field(id, "link", {31'd0, expected.link}, {31'd0, out_link});
                    compare_field(id, "link_pc", expected.link_pc, out_link_pc);
                    compare_field(id, "exc", {31'd0, expected.exc}, {31'd0, out_exc});
                    compare_field(id, "unknown", {31'd0, expected.unknown},
                                  {31'd0, out_unknown});
                end
            end
            give_next = (freed > 0) && release_ok;
            if (give_next) begin
                freed--;
            end
            pending = exp_q.size();
        end
    end

    // one credit per pulse, applied just after the edge.
    always @(posedge clk) begin
        #1;
        credit_drv = give_next;
    end

endmodule

`default_nettype wire

// ==== verification/branch_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_chk #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 4
) (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);
    int credits;       // downstream credits held by the unit.
    int occupancy;     // request queue fill level.
    int fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= OUT_CREDITS;
            occupancy <= 0;
        end else begin
            credits   <= credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
            occupancy <= occupancy + (in_valid ? 1 : 0) - (in_credit ? 1 : 0);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> credits > 0)
        else begin
            $error("out_valid raised with no downstream credit");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) in_valid |-> occupancy < IN_DEPTH)
        else begin
            $error("request queue pushed while full");
            fail_count++;
        end

    assert property (@(posedge clk) !arst_n |-> !in_credit && !out_valid)
        else begin
            $error("in_credit or out_valid high during reset");
            fail_count++;
        end

endmodule

bind branch_unit branch_unit_chk #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) chk_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

`default_nettype wire

// ==== verification/branch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_tb import branch_pkg::*; ();
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 3000;

    logic        clk, arst_n;
    logic        in_valid = 1'b0;
    addr_t       in_pc = '0;
    instr_t      in_instr = '0;
    word_t       in_rs_val = '0;
    word_t       in_rt_val = '0;
    logic        in_credit, out_valid, out_link, out_exc, out_unknown, out_credit;
    addr_t       out_new_pc, out_link_pc;
    int          test_id = 0;
    logic        throttle = 1'b0;
    logic        release_ok = 1'b1;
    int          credits_used = 0;
    int          credits_back = 0;
    int          timeouts = 0;
    int          error_count, request_count, result_count, outstanding;
    logic [31:0] stim_lfsr = 32'h235f;
    logic [31:0] gap_lfsr = 32'h235f;

    branch_unit_clkgen clkgen_inst (.clk(clk), .arst_n(arst_n));

    branch_unit #(
        .IN_DEPTH    (DEF_IN_DEPTH),
        .OUT_DEPTH   (DEF_OUT_DEPTH),
        .OUT_CREDITS (DEF_OUT_DEPTH)
    ) branch_unit_inst (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_pc(in_pc),
        .in_instr(in_instr), .in_rs_val(in_rs_val), .in_rt_val(in_rt_val),
        .in_credit(in_credit), .out_valid(out_valid), .out_new_pc(out_new_pc),
        .out_link(out_link), .out_link_pc(out_link_pc), .out_exc(out_exc),
        .out_unknown(out_unknown), .out_credit(out_credit)
    );

    branch_unit_checker checker_inst (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_pc(in_pc),
        .in_instr(in_instr), .in_rs_val(in_rs_val), .in_rt_val(in_rt_val),
        .test_id(test_id), .out_valid(out_valid), .out_new_pc(out_new_pc),
        .out_link(out_link), .out_link_pc(out_link_pc), .out_exc(out_exc),
        .out_unknown(out_unknown), .release_ok(release_ok), .out_credit(out_credit),
        .error_count(error_count), .request_count(request_count),
        .result_count(result_count), .outstanding(outstanding)
    );

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(inout logic [31:0] state, input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    function automatic instr_t itype(input logic [5:0] op, input logic [4:0] rt,
                                     input logic [15:0] imm);
        return {op, 5'd2, rt, imm};
    endfunction

    function automatic instr_t jtype(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic send_req(input addr_t pc, input instr_t instr, input word_t rs,
                            input word_t rt);
        int waited;
        waited = 0;
        while (credits_used - credits_back >= DEF_IN_DEPTH && waited < WAIT_LIMIT) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
            waited++;
        end
        if (credits_used - credits_back >= DEF_IN_DEPTH) begin
            $display("no request credit came back within %0d cycles", WAIT_LIMIT);
            timeouts++;
        end else begin
            in_valid  = 1'b1;
            in_pc     = pc;
            in_instr  = instr;
            in_rs_val = rs;
            in_rt_val = rt;
            credits_used++;
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && in_credit) begin
            credits_back++;
        end
    end

    // chooses when the downstream side may hand back a credit.
    always @(posedge clk) begin
        logic [31:0] bits;
        #1;
        if (throttle) begin
            draw(gap_lfsr, 2, bits);
            release_ok = (bits[1:0] == 2'b00);
        end else begin
            release_ok = 1'b1;
        end
    end

    initial begin
        int          waited;
        int          count_errors;
        logic [31:0] r_op, r_sel, r_pick, r_rs, r_eq, r_rt, r_imm, r_pc;
        logic [4:0]  sel;
        count_errors = 0;
        waited = 0;
        while (arst_n !== 1'b1 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            timeouts++;
        end
        @(posedge clk);
        #1;

        test_id = 1;
        send_req(32'h0000_1000, itype(OP_BEQ, 5'd3, 16'h0010), 32'd5, 32'd5);
        send_req(32'h0000_1010, itype(OP_BEQ, 5'd3, 16'hfff0), 32'd5, 32'hffff_fffb);
        send_req(32'h0000_1020, itype(OP_BNE, 5'd3, 16'hfff0), 32'd5, 32'hffff_fffb);
        send_req(32'h0000_1030, itype(OP_BNE, 5'd3, 16'h0004), 32'd9, 32'd9);
        send_req(32'h0000_1040, itype(OP_BLEZ, 5'd0, 16'h0020), 32'd0, 32'd0);
        send_req(32'h0000_1050, itype(OP_BLEZ, 5'd0, 16'h0020), 32'd1, 32'd0);
        send_req(32'h0000_1060, itype(OP_BLEZ, 5'd0, 16'h8000), 32'h8000_0000, 32'd0);
        send_req(32'h0000_1070, itype(OP_BGTZ, 5'd0, 16'h0008), 32'd7, 32'd0);
        send_req(32'h0000_1080, itype(OP_BGTZ, 5'd0, 16'h0008), 32'd0, 32'd0);
        send_req(32'h0000_1090, itype(OP_BGTZ, 5'd0, 16'h0008), 32'hffff_ffff, 32'd0);

        test_id = 2;
        send_req(32'h0040_0000, itype(OP_BTYPE, BR_BLTZ, 16'h0100), 32'hffff_ffff, 32'd0);
        send_req(32'h0040_0010, itype(OP_BTYPE, BR_BLTZ, 16'h0100), 32'd0, 32'd0);
        send_req(32'h0040_0020, itype(OP_BTYPE, BR_BGEZ, 16'hff00), 32'd0, 32'd0);
        send_req(32'h0040_0030, itype(OP_BTYPE, BR_BGEZ, 16'hff00), 32'hffff_fffd, 32'd0);
        send_req(32'h0040_0040, itype(OP_BTYPE, BR_BLTZAL, 16'h0040), 32'd4, 32'd0);
        send_req(32'h0040_0050, itype(OP_BTYPE, BR_BLTZAL, 16'h0040), 32'hffff_fffc, 32'd0);
        send_req(32'h0040_0060, itype(OP_BTYPE, BR_BGEZAL, 16'hffc0), 32'hffff_ffff, 32'd0);
        send_req(32'h0040_0070, itype(OP_BTYPE, BR_BGEZAL, 16'hffc0), 32'd9, 32'd0);

        test_id = 3;
        send_req(32'ha000_0100, jtype(OP_J, 26'h012_3456), 32'd0, 32'd0);
        send_req(32'hf000_0000, jtype(OP_JAL, 26'h3ff_ffff), 32'd0, 32'd0);

        test_id = 4;
        send_req(32'h0000_2000, itype(OP_BTYPE, 5'd3, 16'h0010), 32'hffff_ffff, 32'd0);
        send_req(32'h0000_2010, itype(OP_BTYPE, 5'd18, 16'h0010), 32'd1, 32'd0);
        send_req(32'h0000_2020, itype(6'h23, 5'd4, 16'h0010), 32'd1, 32'd1);
        send_req(32'h0000_2030, itype(6'h00, 5'd4, 16'h0010), 32'd1, 32'd1);

        // burst as fast as credits allow while downstream stalls.
        test_id  = 5;
        throttle = 1'b1;
        repeat (60) begin
            draw(stim_lfsr, 3, r_op);
            draw(stim_lfsr, 5, r_sel);
            draw(stim_lfsr, 1, r_pick);
            draw(stim_lfsr, 32, r_rs);
            draw(stim_lfsr, 1, r_eq);
            draw(stim_lfsr, 32, r_rt);
            draw(stim_lfsr, 16, r_imm);
            draw(stim_lfsr, 32, r_pc);
            sel = r_pick[0] ? {r_sel[4], 3'b000, r_sel[0]} : r_sel[4:0];
            send_req({r_pc[31:2], 2'b00}, itype({3'b000, r_op[2:0]}, sel, r_imm[15:0]),
                     r_rs, r_eq[0] ? r_rs : r_rt);
        end
        in_valid = 1'b0;

        waited = 0;
        while ((outstanding != 0 || result_count != credits_used) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (outstanding != 0) begin
            $display("timed out with %0d results still outstanding", outstanding);
            timeouts++;
        end
        if (result_count != credits_used || request_count != credits_used) begin
            $display("sent %0d requests but the unit took %0d and returned %0d results",
                     credits_used, request_count, result_count);
            count_errors++;
        end
        throttle = 1'b0;

        $display("errors: %0d mismatches, %0d count errors, %0d timeouts, %0d assertion fails",
                 error_count, count_errors, timeouts, branch_unit_inst.chk_inst.fail_count);
        if (error_count + count_errors + timeouts + branch_unit_inst.chk_inst.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== branch_unit.f ====
src/branch_pkg.sv
src/credit_fifo.sv
src/branch_cond_eval.sv
src/branch_target_calc.sv
src/branch_resolve.sv
src/branch_unit.sv
verification/branch_unit_clkgen.sv
verification/branch_unit_checker.sv
verification/branch_unit_chk.sv
verification/branch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module branch_unit_tb \
    -f branch_unit.f \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vbranch_unit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1
